// ==== design/tdc_defines.svh ====
`ifndef TDC_DEFINES_SVH
`define TDC_DEFINES_SVH

// host flow control
`define TDC_CMD_CREDITS 2

// spi framing
`define TDC_SPI_DIV     2   // clocks per sclk half period
`define TDC_CS_SETUP    2
`define TDC_CS_GAP      2
`define TDC_CFG_LAST    9   // arming word index

// measurement timing
`define TDC_TRIG_FILT   3
`define TDC_STOP_DLY    16
`define TDC_EN_LOW      4

`define TDC_CMD_START   8'h68   // "h"
`define TDC_CMD_ABORT   8'h73   // "s"

`endif

// ==== design/tdc_pkg.sv ====
package tdc_pkg;

  typedef logic [7:0]  cmd_byte_t;   // one host command byte
  typedef logic [3:0]  cfg_addr_t;   // config table index
  typedef logic [15:0] cfg_word_t;   // one spi frame to the chip

  // measurement sequencer states
  typedef enum logic [2:0] {
    idle,
    cs_setup,
    shift,
    cs_gap,
    trig_wait,
    stop_wait,
    en_low
  } ctrl_state_t;

endpackage

// ==== design/cmd_rx.sv ====
`timescale 1ns/1ps
`include "tdc_defines.svh"

module cmd_rx (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  tdc_pkg::cmd_byte_t  cmd_data,
  output logic                cmd_credit,
  output logic                go,
  output logic                abort
);
  import tdc_pkg::*;

  localparam int DEPTH = `TDC_CMD_CREDITS;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  localparam logic [PW-1:0] PTR_LAST = PW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL     = CW'(DEPTH);

  cmd_byte_t     mem [DEPTH];
  cmd_byte_t     head;
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  assign head = mem[rd_ptr];
  assign pop  = (count != '0);   // drain one byte every cycle

  // every pop frees an entry and hands a credit back
  assign cmd_credit = pop;
  assign go         = pop && (head == `TDC_CMD_START);
  assign abort      = pop && (head == `TDC_CMD_ABORT);

  always_ff @(posedge clk) begin
    if (cmd_valid) mem[wr_ptr] <= cmd_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_valid) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)       rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      case ({cmd_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // host must never send without a credit in hand
  assert property (@(posedge clk) disable iff (rst) cmd_valid |-> count != FULL)
    else $error("cmd_rx: byte 0x%02h arrived with buffer full", cmd_data);

endmodule

// ==== design/tdc_cfg_rom.sv ====
`timescale 1ns/1ps
`include "tdc_defines.svh"

module tdc_cfg_rom (
  input  logic               clk,
  input  tdc_pkg::cfg_addr_t cfg_addr,
  output tdc_pkg::cfg_word_t cfg_word
);

  // high byte 0x40 + k, low byte k * 0x11
  always_ff @(posedge clk) begin
    case (cfg_addr)
      4'd0:                cfg_word <= 16'h4000;
      4'd1:                cfg_word <= 16'h4111;
      4'd2:                cfg_word <= 16'h4222;
      4'd3:                cfg_word <= 16'h4333;
      4'd4:                cfg_word <= 16'h4444;
      4'd5:                cfg_word <= 16'h4555;
      4'd6:                cfg_word <= 16'h4666;
      4'd7:                cfg_word <= 16'h4777;
      4'd8:                cfg_word <= 16'h4888;
      4'(`TDC_CFG_LAST):   cfg_word <= 16'h4003;   // arms the chip
      default:             cfg_word <= 16'h0000;
    endcase
  end

endmodule

// ==== design/tdc_control.sv ====
`timescale 1ns/1ps
`include "tdc_defines.svh"

module tdc_control (
  input  logic               clk,
  input  logic               rst,
  input  logic               go,
  input  logic               abort,
  input  logic               spi_done,
  input  logic               tdc_trig,
  output tdc_pkg::cfg_addr_t cfg_addr,
  output logic               spi_start,
  output logic               spi_cancel,
  output logic               cs_n,
  output logic               enable,
  output logic               start_signal,
  output logic               stop_signal
);
  import tdc_pkg::*;

  // terminal counts of the shared timer
  localparam logic [4:0] SETUP_LAST = 5'(`TDC_CS_SETUP - 1);
  localparam logic [4:0] GAP_LAST   = 5'(`TDC_CS_GAP - 1);
  localparam logic [4:0] FILT_LAST  = 5'(`TDC_TRIG_FILT - 1);
  localparam logic [4:0] STOP_LAST  = 5'(`TDC_STOP_DLY - 1);
  localparam logic [4:0] EN_LAST    = 5'(`TDC_EN_LOW - 1);

  localparam cfg_addr_t ADDR_LAST = cfg_addr_t'(`TDC_CFG_LAST);

  ctrl_state_t state;
  logic [4:0]  cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= idle;
      cnt          <= '0;
      cfg_addr     <= '0;
      spi_start    <= 1'b0;
      spi_cancel   <= 1'b0;
      cs_n         <= 1'b1;
      enable       <= 1'b1;
      start_signal <= 1'b0;
      stop_signal  <= 1'b0;
    end else begin
      // single cycle strobes
      spi_start    <= 1'b0;
      spi_cancel   <= 1'b0;
      start_signal <= 1'b0;
      stop_signal  <= 1'b0;

      if (abort) begin
        // hardware reset of the chip from any state
        state      <= en_low;
        cnt        <= '0;
        cfg_addr   <= '0;
        cs_n       <= 1'b1;
        enable     <= 1'b0;
        spi_cancel <= 1'b1;
      end else begin
        case (state)
          idle: begin
            if (go) begin
              state    <= cs_setup;
              cnt      <= '0;
              cfg_addr <= '0;
              cs_n     <= 1'b0;
            end
          end

          cs_setup: begin
            // rom word settles while cs is already low
            if (cnt == SETUP_LAST) begin
              state     <= shift;
              cnt       <= '0;
              spi_start <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end

          shift: begin
            if (spi_done) begin
              cs_n  <= 1'b1;
              cnt   <= '0;
              state <= (cfg_addr == ADDR_LAST) ? trig_wait : cs_gap;
            end
          end

          cs_gap: begin
            if (cnt == GAP_LAST) begin
              state    <= cs_setup;
              cnt      <= '0;
              cfg_addr <= cfg_addr + 1'b1;   // next table entry
              cs_n     <= 1'b0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end

          trig_wait: begin
            // count consecutive high samples, any low restarts
            if (!tdc_trig) begin
              cnt <= '0;
            end else if (cnt == FILT_LAST) begin
              state        <= stop_wait;
              cnt          <= '0;
              start_signal <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end

          stop_wait: begin
            if (cnt == STOP_LAST) begin
              state       <= idle;
              cnt         <= '0;
              stop_signal <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end

          en_low: begin
            if (cnt == EN_LAST) begin
              state  <= idle;
              cnt    <= '0;
              enable <= 1'b1;   // chip released
            end else begin
              cnt <= cnt + 1'b1;
            end
          end

          default: begin
            state <= idle;
            cnt   <= '0;
          end
        endcase
      end
    end
  end

  // a frame only starts inside a chip select window
  assert property (@(posedge clk) disable iff (rst) spi_start |-> !cs_n)
    else $error("tdc_control: spi_start with cs_n high, addr 0x%01h", cfg_addr);

  assert property (@(posedge clk) disable iff (rst) !(start_signal && stop_signal))
    else $error("tdc_control: start and stop pulses overlap");

endmodule

// ==== design/spi_master.sv ====
`timescale 1ns/1ps
`include "tdc_defines.svh"

module spi_master (
  input  logic               clk,
  input  logic               rst,
  input  logic               spi_start,
  input  logic               spi_cancel,
  input  tdc_pkg::cfg_word_t cfg_word,
  output logic               spi_busy,
  output logic               spi_done,
  output logic               sclk,
  output logic               mosi
);
  import tdc_pkg::*;

  localparam int DIV = `TDC_SPI_DIV;

  localparam logic [3:0] DIV_LAST = 4'(DIV - 1);
  localparam logic [3:0] DIV_DONE = 4'(DIV - 2);   // last high phase ends a cycle early

  cfg_word_t  shift_reg;
  logic [3:0] div_cnt;
  logic [3:0] bit_cnt;
  logic       launch;
  logic       fall;
  logic       last;

  assign launch = spi_start && !spi_busy;
  // end of a high phase, data moves on with the falling edge
  assign fall   = spi_busy && sclk && (div_cnt == DIV_LAST);
  assign last   = spi_busy && sclk && (bit_cnt == 4'hf) && (div_cnt == DIV_DONE);

  assign mosi = spi_busy && shift_reg[15];   // msb first

  always_ff @(posedge clk) begin
    if (rst || spi_cancel) begin
      spi_busy <= 1'b0;
      spi_done <= 1'b0;
      sclk     <= 1'b1;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      spi_done <= 1'b0;
      if (launch) begin
        spi_busy <= 1'b1;
        sclk     <= 1'b0;   // first low phase holds bit 15
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end else if (last) begin
        // sclk is already high, which is its idle level
        spi_busy <= 1'b0;
        spi_done <= 1'b1;
        div_cnt  <= '0;
      end else if (spi_busy) begin
        if (div_cnt == DIV_LAST) begin
          div_cnt <= '0;
          sclk    <= ~sclk;
          if (sclk) bit_cnt <= bit_cnt + 1'b1;
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      shift_reg <= cfg_word;
    end else if (fall) begin
      shift_reg <= {shift_reg[14:0], 1'b0};
    end
  end

  // sequencer must wait for the previous frame to finish
  assert property (@(posedge clk) disable iff (rst) spi_start |-> !spi_busy)
    else $error("spi_master: spi_start while busy, word 0x%04h", cfg_word);

endmodule

// ==== design/tdc_top.sv ====
`timescale 1ns/1ps

module tdc_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_valid,
  input  tdc_pkg::cmd_byte_t cmd_data,
  output logic               cmd_credit,
  input  logic               tdc_trig,
  output logic               sclk,
  output logic               mosi,
  output logic               cs_n,
  output logic               enable,
  output logic               start_signal,
  output logic               stop_signal
);
  import tdc_pkg::*;

  logic      go;
  logic      abort;
  logic      spi_start;
  logic      spi_cancel;
  logic      spi_done;
  cfg_addr_t cfg_addr;
  cfg_word_t cfg_word;

  // host bytes in, start and abort strobes out
  cmd_rx u_cmd_rx (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .cmd_credit (cmd_credit),
    .go         (go),
    .abort      (abort)
  );

  tdc_control u_tdc_control (
    .clk          (clk),
    .rst          (rst),
    .go           (go),
    .abort        (abort),
    .spi_done     (spi_done),
    .tdc_trig     (tdc_trig),
    .cfg_addr     (cfg_addr),
    .spi_start    (spi_start),
    .spi_cancel   (spi_cancel),
    .cs_n         (cs_n),
    .enable       (enable),
    .start_signal (start_signal),
    .stop_signal  (stop_signal)
  );

  tdc_cfg_rom u_tdc_cfg_rom (
    .clk      (clk),
    .cfg_addr (cfg_addr),
    .cfg_word (cfg_word)
  );

  // busy is only watched inside the master
  spi_master u_spi_master (
    .clk        (clk),
    .rst        (rst),
    .spi_start  (spi_start),
    .spi_cancel (spi_cancel),
    .cfg_word   (cfg_word),
    .spi_busy   (),
    .spi_done   (spi_done),
    .sclk       (sclk),
    .mosi       (mosi)
  );

endmodule

// ==== tests/tb_tdc_top.sv ====
`timescale 1ns/1ps
`include "tdc_defines.svh"

module tb_tdc_top;
  import tdc_pkg::*;

  localparam int WORDS = `TDC_CFG_LAST + 1;

  logic      clk;
  logic      rst;
  logic      cmd_valid;
  cmd_byte_t cmd_data;
  logic      cmd_credit;
  logic      tdc_trig;
  logic      sclk;
  logic      mosi;
  logic      cs_n;
  logic      enable;
  logic      start_signal;
  logic      stop_signal;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          sent;            // bytes the host has driven
  int          back;            // credit pulses seen
  int          cyc;
  int          bits;
  cfg_word_t   word;
  int          low_len;
  int          trig_rise_cyc;
  logic        idle_expected;   // chip side must stay quiet
  logic        prev_cs_n;
  logic        prev_sclk;
  logic        prev_enable;
  logic        prev_trig;
  int          frame_bits[$];
  cfg_word_t   frame_words[$];
  int          start_cycles[$];
  int          stop_cycles[$];
  int          en_low_lens[$];

  tdc_top DUT (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_data     (cmd_data),
    .cmd_credit   (cmd_credit),
    .tdc_trig     (tdc_trig),
    .sclk         (sclk),
    .mosi         (mosi),
    .cs_n         (cs_n),
    .enable       (enable),
    .start_signal (start_signal),
    .stop_signal  (stop_signal)
  );

  always #50 clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int unsigned random_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = (r << 1) | lfsr[0];
    end
    return r;
  endfunction

  // table rule for the configuration words
  function automatic cfg_word_t expected_word(input int k);
    if (k == `TDC_CFG_LAST) return 16'h4003;
    return {8'h40 + 8'(k), 8'(k) * 8'h11};
  endfunction

  function automatic cmd_byte_t other_byte();
    cmd_byte_t b;
    b = cmd_byte_t'(random_bits(8));
    if (b == `TDC_CMD_START || b == `TDC_CMD_ABORT) b = b ^ 8'h01;
    return b;
  endfunction

  function automatic int credits_held();
    return `TDC_CMD_CREDITS - sent + back;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("error %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
      end
  endtask

  task automatic check_that(input logic ok, input string what);
    checks++;
    assert (ok)
      else begin
        errors++;
        $display("failure at cycle %0d: %s", cyc, what);
      end
  endtask

  task automatic give_up(input string what);
    errors++;
    $display("timeout at cycle %0d: %s", cyc, what);
    $display("checks %0d, errors %0d", checks, errors);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input cmd_byte_t b);
    int n;
    n = 0;
    while (credits_held() == 0) begin
      if (n == 20) give_up("no credit came back to the host");
      next_cycle();
      n++;
    end
    cmd_valid = 1'b1;
    cmd_data  = b;
    sent++;
    next_cycle();
    cmd_valid = 1'b0;
  endtask

  task automatic wait_credits_home();
    int n;
    n = 0;
    while (back != sent) begin
      if (n == 20) give_up("credits still outstanding");
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_frames(input int count);
    int n;
    n = 0;
    while (frame_bits.size() < count) begin
      if (n > 2000) give_up("spi words did not all arrive");
      if (random_bits(5) == 0) begin
        // stray bytes during the sequence must not disturb it
        send_byte(random_bits(1) ? `TDC_CMD_START : other_byte());
      end else begin
        next_cycle();
      end
      n++;
    end
  endtask

  task automatic run_measurement();
    int n;
    frame_bits.delete();
    frame_words.delete();
    start_cycles.delete();
    stop_cycles.delete();
    send_byte(`TDC_CMD_START);
    wait_frames(WORDS);
    for (int k = 0; k < WORDS; k++) begin
      check_value("frame bits", frame_bits[k], 16);
      check_value("mosi word", frame_words[k], expected_word(k));
    end
    repeat (1 + random_bits(2)) begin   // glitches below the filter length
      tdc_trig = 1'b1;
      repeat (1 + random_bits(1)) next_cycle();
      tdc_trig = 1'b0;
      repeat (1 + random_bits(2)) next_cycle();
    end
    repeat (4) next_cycle();
    check_that(start_cycles.size() == 0, "start_signal after a short trigger glitch");
    tdc_trig = 1'b1;
    n = 0;
    while (start_cycles.size() == 0) begin
      if (n == 20) give_up("no start_signal for a held trigger");
      next_cycle();
      n++;
    end
    check_value("start_signal cycle", start_cycles[0], trig_rise_cyc + `TDC_TRIG_FILT);
    send_byte(`TDC_CMD_START);   // ignored outside idle
    n = 0;
    while (stop_cycles.size() == 0) begin
      if (n == 40) give_up("no stop_signal after start_signal");
      next_cycle();
      n++;
    end
    check_value("stop delay", stop_cycles[0] - start_cycles[0], `TDC_STOP_DLY);
    repeat (8) next_cycle();
    tdc_trig = 1'b0;
    repeat (4) next_cycle();
    check_value("start_signal count", start_cycles.size(), 1);
    check_value("stop_signal count", stop_cycles.size(), 1);
    check_value("frame count", frame_bits.size(), WORDS);
  endtask

  task automatic run_abort(input logic in_trig_wait);
    int n;
    frame_bits.delete();
    start_cycles.delete();
    send_byte(`TDC_CMD_START);
    if (in_trig_wait) begin
      wait_frames(WORDS);
      repeat (random_bits(3)) next_cycle();
    end else begin
      repeat (random_bits(9)) next_cycle();   // lands inside configuration
    end
    send_byte(`TDC_CMD_ABORT);
    tdc_trig = 1'b1;   // held trigger after the abort must not start anything
    @(negedge clk);   // abort strobe pops here
    check_value("enable", enable, 1);
    @(negedge clk);
    check_value("cs_n", cs_n, 1);
    check_value("enable", enable, 0);
    n = 0;
    while (!enable) begin
      if (n == 20) give_up("enable stuck low after abort");
      check_value("cs_n", cs_n, 1);
      @(negedge clk);
      n++;
    end
    next_cycle();
    check_value("enable low cycles", en_low_lens[$], `TDC_EN_LOW);
    idle_expected = 1'b1;
    repeat (16) next_cycle();
    idle_expected = 1'b0;
    tdc_trig = 1'b0;
    check_value("start_signal count", start_cycles.size(), 0);
  endtask

  always @(negedge clk) begin
    cyc++;
    if (!rst) begin
      if (cmd_credit) back++;
      check_that(back <= sent, "credit returned for a byte never sent");
      if (!cs_n && prev_cs_n) begin
        bits = 0;
        word = '0;
      end
      if (!cs_n && sclk && !prev_sclk) begin   // chip samples on rising sclk
        word = {word[14:0], mosi};
        bits++;
      end
      if (cs_n && !prev_cs_n) begin
        frame_bits.push_back(bits);
        frame_words.push_back(word);
      end
      if (start_signal) start_cycles.push_back(cyc);
      if (stop_signal) stop_cycles.push_back(cyc);
      if (tdc_trig && !prev_trig) trig_rise_cyc = cyc;
      if (!enable) low_len++;
      if (enable && !prev_enable) begin
        en_low_lens.push_back(low_len);
        low_len = 0;
      end
      if (idle_expected) begin
        check_value("cs_n", cs_n, 1);
        check_value("sclk", sclk, 1);
        check_value("mosi", mosi, 0);
        check_value("enable", enable, 1);
        check_value("start_signal", start_signal, 0);
        check_value("stop_signal", stop_signal, 0);
      end
    end
    prev_cs_n   = cs_n;
    prev_sclk   = sclk;
    prev_enable = enable;
    prev_trig   = tdc_trig;
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    cmd_valid     = 1'b0;
    cmd_data      = '0;
    tdc_trig      = 1'b0;
    lfsr          = 32'h676d;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    back          = 0;
    cyc           = 0;
    bits          = 0;
    word          = '0;
    low_len       = 0;
    trig_rise_cyc = 0;
    idle_expected = 1'b0;
    prev_cs_n     = 1'b1;
    prev_sclk     = 1'b1;
    prev_enable   = 1'b1;
    prev_trig     = 1'b0;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("cs_n", cs_n, 1);
    check_value("sclk", sclk, 1);
    check_value("enable", enable, 1);
    check_value("mosi", mosi, 0);
    check_value("start_signal", start_signal, 0);
    check_value("stop_signal", stop_signal, 0);
    check_value("cmd_credit", cmd_credit, 0);
    next_cycle();

    // other bytes in idle, bursts use up both credits
    idle_expected = 1'b1;
    repeat (24) begin
      send_byte(other_byte());
      repeat (random_bits(2)) next_cycle();
    end
    wait_credits_home();
    repeat (4) next_cycle();
    idle_expected = 1'b0;

    for (int r = 0; r < 3; r++) begin
      run_measurement();
      run_abort(random_bits(1));
    end
    run_measurement();

    wait_credits_home();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/tdc_pkg.sv
design/cmd_rx.sv
design/tdc_cfg_rom.sv
design/tdc_control.sv
design/spi_master.sv
design/tdc_top.sv
tests/tb_tdc_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tdc controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tdc_top -f project.f -o sim_tdc
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tdc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "pass message not found"
exit 1
